/* hw/heapConfigPkg.sv */
//----------------------------------------------------------------------
// Heap geometry: a fixed pool of equal length arrays
// Id and index widths follow from the counts, which must be powers of 2
//----------------------------------------------------------------------
package heapConfigPkg;

  localparam int ARRAY_COUNT  = 4;                      // Arrays in the heap
  localparam int ARRAY_LENGTH = 4;                      // Elements per array
  localparam int DATA_BITS    = 12;                     // Element width
  localparam int ID_BITS      = $clog2(ARRAY_COUNT);    // Bits in an array id
  localparam int INDEX_BITS   = $clog2(ARRAY_LENGTH);   // Bits in an element index

  typedef logic [DATA_BITS-1:0]  heapElement;           // One data word
  typedef logic [ID_BITS-1:0]    arrayId;               // Array number
  typedef logic [INDEX_BITS-1:0] elementIndex;          // Position within an array
  typedef logic [INDEX_BITS:0]   arraySize;             // 0 to ARRAY_LENGTH
  typedef logic [ID_BITS:0]      arrayCount;            // 0 to ARRAY_COUNT

endpackage

/* hw/heapOpsPkg.sv */
//----------------------------------------------------------------------
// Action codes seen at the heap ports, result codes and the internal
// commands of the element store. Codes not listed only clear error
//----------------------------------------------------------------------
package heapOpsPkg;

  typedef enum logic [7:0] {
    actIdle     = 8'd0,                                 // No request this cycle
    actReset    = 8'd1,                                 // Free every array
    actWrite    = 8'd2,
    actRead     = 8'd3,
    actSize     = 8'd4,
    actUp       = 8'd10,                                // Insert, shifting upward
    actPush     = 8'd14,
    actPop      = 8'd15,
    actResize   = 8'd17,
    actAlloc    = 8'd18,
    actFree     = 8'd19,
    actAdd      = 8'd20,                                // Returns new value
    actAddAfter = 8'd21,                                // Returns old value
    actSubtract = 8'd22,
    actSubAfter = 8'd23,
    actOr       = 8'd28,
    actXor      = 8'd29,
    actAnd      = 8'd30
  } heapAction;

  typedef enum logic [2:0] {
    errNone,
    errNotAllocated,                                    // Id never granted since reset
    errFreed,                                           // Id currently on the free stack
    errOutOfBounds,                                     // Index at or above size
    errFull,                                            // Push on a full array
    errEmpty,                                           // Pop on an empty array
    errOutOfMemory,                                     // No id left to grant
    errTooLarge                                         // Resize beyond ARRAY_LENGTH
  } heapErrorCode;

  typedef enum logic [2:0] {
    stIdle,
    stWrite,                                            // Also used by the ALU actions
    stInsert,
    stPush,
    stPop,
    stSetSize
  } storeCommand;

endpackage

/* hw/heapStoreIf.sv */
//----------------------------------------------------------------------
// Command unit to element store. Read data is combinational from the
// addressed array; the store trusts every command it is given
//----------------------------------------------------------------------
`timescale 1ns/1ps

interface heapStoreIf;

  heapOpsPkg::storeCommand    command;                  // Operation this cycle
  heapConfigPkg::arrayId      array;                    // Addressed array
  heapConfigPkg::elementIndex index;                    // Addressed element
  heapConfigPkg::heapElement  data;                     // Write value or new size
  heapConfigPkg::arraySize    size;                     // Size of addressed array
  heapConfigPkg::heapElement  element;                  // Element at index
  heapConfigPkg::heapElement  topElement;               // Element at size - 1

  modport commander (
    output command, array, index, data,
    input  size, element, topElement
  );

  modport store (
    input  command, array, index, data,
    output size, element, topElement
  );

endinterface

/* hw/heapAllocIf.sv */
//----------------------------------------------------------------------
// Command unit to allocator. Requests are one cycle levels taken at
// the clock edge; at most one of allocate and deallocate per cycle
//----------------------------------------------------------------------
`timescale 1ns/1ps

interface heapAllocIf;

  logic                  allocate;                      // Grant grantId
  logic                  deallocate;                    // Push array onto free stack
  logic                  clearAll;                      // Forget every grant
  heapConfigPkg::arrayId array;                         // Id queried or released
  logic                  isAllocated;                   // Queried id is live
  logic                  wasGranted;                    // Queried id handed out once
  heapConfigPkg::arrayId grantId;                       // Id the next allocate returns
  logic                  exhausted;                     // Nothing left to grant

  modport commander (
    output allocate, deallocate, clearAll, array,
    input  isAllocated, wasGranted, grantId, exhausted
  );

  modport allocator (
    input  allocate, deallocate, clearAll, array,
    output isAllocated, wasGranted, grantId, exhausted
  );

endinterface

/* hw/heapAllocator.sv */
//----------------------------------------------------------------------
// Array id allocator. Freed ids are reused last in first out before
// fresh ids are taken. Requests are not checked here
//----------------------------------------------------------------------
`timescale 1ns/1ps

module heapAllocator (
  input logic clock,
  input logic reset,
  heapAllocIf.allocator alloc
);

  logic [heapConfigPkg::ARRAY_COUNT-1:0] allocBits;     // One live bit per array
  heapConfigPkg::arrayCount              grantCount;    // Fresh ids handed out
  heapConfigPkg::arrayCount              freeTop;       // Depth of free stack
  heapConfigPkg::arrayId                 freedIds [heapConfigPkg::ARRAY_COUNT];
  heapConfigPkg::arrayId                 topIndex;      // Slot of newest freed id

  //--------------------------------------------------------------------
  // Status seen by the command unit
  //--------------------------------------------------------------------
  assign topIndex          = heapConfigPkg::arrayId'(freeTop - 1'b1);
  assign alloc.isAllocated = allocBits[alloc.array];
  assign alloc.wasGranted  = {1'b0, alloc.array} < grantCount;
  assign alloc.grantId     = (freeTop != '0) ? freedIds[topIndex]     // Reuse first
                                             : heapConfigPkg::arrayId'(grantCount);
  assign alloc.exhausted   = (freeTop == '0) &&
                             (grantCount == heapConfigPkg::arrayCount'(heapConfigPkg::ARRAY_COUNT));

  //--------------------------------------------------------------------
  // Grant state
  //--------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset || alloc.clearAll) begin
      allocBits  <= '0;
      grantCount <= '0;
      freeTop    <= '0;
    end else if (alloc.allocate) begin
      allocBits[alloc.grantId] <= 1'b1;
      if (freeTop != '0) begin
        freeTop <= freeTop - 1'b1;                      // Pop free stack
      end else begin
        grantCount <= grantCount + 1'b1;                // Take a fresh id
      end
    end else if (alloc.deallocate) begin
      allocBits[alloc.array] <= 1'b0;
      freeTop                <= freeTop + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (alloc.deallocate) begin
      freedIds[heapConfigPkg::arrayId'(freeTop)] <= alloc.array;   // Push free stack
    end
  end

endmodule

/* hw/arrayStore.sv */
//----------------------------------------------------------------------
// Element and size storage for every array. Commands are executed
// as given; bounds and capacity are checked upstream
//----------------------------------------------------------------------
`timescale 1ns/1ps

module arrayStore (
  input logic clock,
  input logic reset,
  heapStoreIf.store store
);

  heapConfigPkg::heapElement   elements [heapConfigPkg::ARRAY_COUNT][heapConfigPkg::ARRAY_LENGTH];
  heapConfigPkg::arraySize     sizes    [heapConfigPkg::ARRAY_COUNT];
  heapConfigPkg::elementIndex  topIndex;                // size - 1 of addressed array
  heapConfigPkg::elementIndex  endIndex;                // First slot past the end
  heapConfigPkg::arraySize     indexPlusOne;            // Size after writing at index

  //--------------------------------------------------------------------
  // Read side
  //--------------------------------------------------------------------
  assign endIndex         = heapConfigPkg::elementIndex'(store.size);
  assign topIndex         = heapConfigPkg::elementIndex'(store.size - 1'b1);
  assign indexPlusOne     = {1'b0, store.index} + 1'b1;
  assign store.size       = sizes[store.array];
  assign store.element    = elements[store.array][store.index];
  assign store.topElement = elements[store.array][topIndex];

  //--------------------------------------------------------------------
  // Sizes
  //--------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int a = 0; a < heapConfigPkg::ARRAY_COUNT; a++) begin
        sizes[a] <= '0;
      end
    end else begin
      unique case (store.command)
        heapOpsPkg::stWrite: begin
          if ({1'b0, store.index} >= store.size) begin
            sizes[store.array] <= indexPlusOne;         // Extend to cover index
          end
        end
        heapOpsPkg::stInsert: begin
          if (store.size < heapConfigPkg::arraySize'(heapConfigPkg::ARRAY_LENGTH)) begin
            sizes[store.array] <= store.size + 1'b1;    // Saturates at full
          end
        end
        heapOpsPkg::stPush:    sizes[store.array] <= store.size + 1'b1;
        heapOpsPkg::stPop:     sizes[store.array] <= store.size - 1'b1;
        heapOpsPkg::stSetSize: sizes[store.array] <= heapConfigPkg::arraySize'(store.data);
        default: ;
      endcase
    end
  end

  //--------------------------------------------------------------------
  // Elements
  //--------------------------------------------------------------------
  always_ff @(posedge clock) begin
    unique case (store.command)
      heapOpsPkg::stWrite: elements[store.array][store.index] <= store.data;
      heapOpsPkg::stInsert: begin
        for (int j = 1; j < heapConfigPkg::ARRAY_LENGTH; j++) begin
          if (j > int'(store.index)) begin
            elements[store.array][j] <= elements[store.array][j-1];   // Top one drops off
          end
        end
        elements[store.array][store.index] <= store.data;
      end
      heapOpsPkg::stPush: elements[store.array][endIndex] <= store.data;
      default: ;
    endcase
  end

endmodule

/* hw/heapCommandUnit.sv */
//----------------------------------------------------------------------
// Action decoder. A nonzero action is the request; it is checked,
// executed and its out and error are registered in one cycle
//----------------------------------------------------------------------
`timescale 1ns/1ps

module heapCommandUnit (
  input  logic                        clock,
  input  logic                        reset,
  input  heapOpsPkg::heapAction       action,
  input  heapConfigPkg::arrayId       array,
  input  heapConfigPkg::elementIndex  index,
  input  heapConfigPkg::heapElement   in,
  output heapConfigPkg::heapElement   out,
  output heapOpsPkg::heapErrorCode    error,
  heapAllocIf.commander               alloc,
  heapStoreIf.commander               store
);

  heapOpsPkg::heapErrorCode  allocErr;                  // Allocated check alone
  heapOpsPkg::heapErrorCode  checkErr;                  // Final verdict
  heapOpsPkg::storeCommand   storeCmd;                  // Command before gating
  heapConfigPkg::heapElement aluResult;                 // New element value
  heapConfigPkg::heapElement nextOut;
  logic                      ok;

  //--------------------------------------------------------------------
  // Checks, in priority order
  //--------------------------------------------------------------------
  assign allocErr = !alloc.wasGranted  ? heapOpsPkg::errNotAllocated :
                    !alloc.isAllocated ? heapOpsPkg::errFreed : heapOpsPkg::errNone;

  always_comb begin
    checkErr = heapOpsPkg::errNone;
    unique case (action)
      heapOpsPkg::actWrite, heapOpsPkg::actSize, heapOpsPkg::actUp,
      heapOpsPkg::actPush, heapOpsPkg::actPop, heapOpsPkg::actResize,
      heapOpsPkg::actFree:
        checkErr = allocErr;
      heapOpsPkg::actRead, heapOpsPkg::actAdd, heapOpsPkg::actAddAfter,
      heapOpsPkg::actSubtract, heapOpsPkg::actSubAfter, heapOpsPkg::actOr,
      heapOpsPkg::actXor, heapOpsPkg::actAnd: begin
        checkErr = allocErr;
        if (allocErr == heapOpsPkg::errNone && {1'b0, index} >= store.size) begin
          checkErr = heapOpsPkg::errOutOfBounds;
        end
      end
      default: ;
    endcase
    if (checkErr == heapOpsPkg::errNone) begin          // Capacity last
      if (action == heapOpsPkg::actPush &&
          store.size == heapConfigPkg::arraySize'(heapConfigPkg::ARRAY_LENGTH)) begin
        checkErr = heapOpsPkg::errFull;
      end else if (action == heapOpsPkg::actPop && store.size == '0) begin
        checkErr = heapOpsPkg::errEmpty;
      end else if (action == heapOpsPkg::actResize &&
                   in > heapConfigPkg::heapElement'(heapConfigPkg::ARRAY_LENGTH)) begin
        checkErr = heapOpsPkg::errTooLarge;
      end else if (action == heapOpsPkg::actAlloc && alloc.exhausted) begin
        checkErr = heapOpsPkg::errOutOfMemory;
      end
    end
  end

  assign ok = (checkErr == heapOpsPkg::errNone);

  //--------------------------------------------------------------------
  // Element ALU, wraps at DATA_BITS
  //--------------------------------------------------------------------
  always_comb begin
    unique case (action)
      heapOpsPkg::actAdd, heapOpsPkg::actAddAfter:      aluResult = store.element + in;
      heapOpsPkg::actSubtract, heapOpsPkg::actSubAfter: aluResult = store.element - in;
      heapOpsPkg::actOr:  aluResult = store.element | in;
      heapOpsPkg::actXor: aluResult = store.element ^ in;
      heapOpsPkg::actAnd: aluResult = store.element & in;
      default:            aluResult = in;               // Plain write value
    endcase
  end

  //--------------------------------------------------------------------
  // Command and result selection
  //--------------------------------------------------------------------
  always_comb begin
    storeCmd = heapOpsPkg::stIdle;
    nextOut  = out;                                     // Hold unless a result exists
    unique case (action)
      heapOpsPkg::actWrite: begin
        storeCmd = heapOpsPkg::stWrite;
        nextOut  = in;
      end
      heapOpsPkg::actRead:   nextOut  = store.element;
      heapOpsPkg::actSize:   nextOut  = heapConfigPkg::heapElement'(store.size);
      heapOpsPkg::actUp:     storeCmd = heapOpsPkg::stInsert;
      heapOpsPkg::actPush:   storeCmd = heapOpsPkg::stPush;
      heapOpsPkg::actPop: begin
        storeCmd = heapOpsPkg::stPop;
        nextOut  = store.topElement;
      end
      heapOpsPkg::actResize: storeCmd = heapOpsPkg::stSetSize;
      heapOpsPkg::actAlloc: begin
        storeCmd = heapOpsPkg::stSetSize;               // New array starts empty
        nextOut  = heapConfigPkg::heapElement'(alloc.grantId);
      end
      heapOpsPkg::actAddAfter, heapOpsPkg::actSubAfter: begin
        storeCmd = heapOpsPkg::stWrite;
        nextOut  = store.element;                       // Value before update
      end
      heapOpsPkg::actAdd, heapOpsPkg::actSubtract, heapOpsPkg::actOr,
      heapOpsPkg::actXor, heapOpsPkg::actAnd: begin
        storeCmd = heapOpsPkg::stWrite;
        nextOut  = aluResult;
      end
      default: ;
    endcase
  end

  assign alloc.array      = array;
  assign alloc.allocate   = ok && (action == heapOpsPkg::actAlloc);
  assign alloc.deallocate = ok && (action == heapOpsPkg::actFree);
  assign alloc.clearAll   = (action == heapOpsPkg::actReset);
  assign store.command    = ok ? storeCmd : heapOpsPkg::stIdle;
  assign store.array      = (action == heapOpsPkg::actAlloc) ? alloc.grantId : array;
  assign store.index      = index;
  assign store.data       = (action == heapOpsPkg::actAlloc) ? '0 : aluResult;

  //--------------------------------------------------------------------
  // Output registers
  //--------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      out   <= '0;
      error <= heapOpsPkg::errNone;
    end else if (action != heapOpsPkg::actIdle) begin
      error <= checkErr;
      if (ok) begin
        out <= nextOut;
      end
    end
  end

endmodule

/* hw/heapMemory.sv */
//----------------------------------------------------------------------
// Heap memory top. One action per cycle, results one edge later
// No handshake; a nonzero action is the request
//----------------------------------------------------------------------
`timescale 1ns/1ps

module heapMemory (
  input  logic                        clock,
  input  logic                        reset,
  input  heapOpsPkg::heapAction       action,
  input  heapConfigPkg::arrayId       array,
  input  heapConfigPkg::elementIndex  index,
  input  heapConfigPkg::heapElement   in,
  output heapConfigPkg::heapElement   out,
  output heapOpsPkg::heapErrorCode    error
);

  heapAllocIf allocBus ();                              // Command unit to allocator
  heapStoreIf storeBus ();                              // Command unit to store

  heapCommandUnit u_commandUnit (
    .clock  (clock),
    .reset  (reset),
    .action (action),
    .array  (array),
    .index  (index),
    .in     (in),
    .out    (out),
    .error  (error),
    .alloc  (allocBus.commander),
    .store  (storeBus.commander)
  );

  heapAllocator u_allocator (
    .clock (clock),
    .reset (reset),
    .alloc (allocBus.allocator)
  );

  arrayStore u_store (
    .clock (clock),
    .reset (reset),
    .store (storeBus.store)
  );

endmodule

/* tests/heapMemoryTb.sv */
//----------------------------------------------------------------------
// Directed testbench for the heap memory. Inputs change 1 ns after a
// rising edge, results are sampled 1 ns after the following edge
//----------------------------------------------------------------------
`timescale 1ns/1ps

module heapMemoryTb;

  localparam int POLL_LIMIT = 100;                      // 2 ns polls, two clock periods

  logic                       clock;
  logic                       reset;
  heapOpsPkg::heapAction      action;
  heapConfigPkg::arrayId      array;
  heapConfigPkg::elementIndex index;
  heapConfigPkg::heapElement  in;
  heapConfigPkg::heapElement  out;
  heapOpsPkg::heapErrorCode   error;

  int unsigned                edgeCount = 0;            // Rising edges seen so far
  logic [31:0]                randState = 32'h9184;     // Operand generator state
  heapConfigPkg::heapElement  expectedOut;              // Model of the out register

  heapMemory u_dut (
    .clock  (clock),
    .reset  (reset),
    .action (action),
    .array  (array),
    .index  (index),
    .in     (in),
    .out    (out),
    .error  (error)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;                         // 100 ns period
  end

  always @(posedge clock) edgeCount <= edgeCount + 1;

  //--------------------------------------------------------------------
  // Failure reporting and compares
  //--------------------------------------------------------------------
  task automatic stopOnFailure;
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic checkElement(string name, heapConfigPkg::heapElement actual,
                              heapConfigPkg::heapElement expected);
    if (actual !== expected) begin
      $display("ERROR %s got 0x%h expected 0x%h", name, actual, expected);
      stopOnFailure();
    end
  endtask

  task automatic checkError(string name, heapOpsPkg::heapErrorCode actual,
                            heapOpsPkg::heapErrorCode expected);
    if (actual !== expected) begin
      $display("ERROR %s got 0x%h expected 0x%h", name, actual, expected);
      stopOnFailure();
    end
  endtask

  //--------------------------------------------------------------------
  // Timing and stimulus helpers
  //--------------------------------------------------------------------
  // Polls at odd ns only, so never in the same step as an edge
  task automatic waitForEdge;
    int unsigned target;
    int unsigned polls;
    target = edgeCount + 1;
    polls  = 0;
    while (edgeCount < target) begin
      if (polls == POLL_LIMIT) begin
        $display("Timed out waiting for a rising clock edge");
        stopOnFailure();
      end
      #2;
      polls++;
    end
  endtask

  function automatic heapConfigPkg::heapElement nextOperand();
    randState = randState ^ (randState << 13);          // xorshift32
    randState = randState ^ (randState >> 17);
    randState = randState ^ (randState << 5);
    return randState[heapConfigPkg::DATA_BITS-1:0];
  endfunction

  // Expected element value after an arithmetic action, wraps at 12 bits
  function automatic heapConfigPkg::heapElement applyOperation(
      heapOpsPkg::heapAction act, heapConfigPkg::heapElement current,
      heapConfigPkg::heapElement operand);
    case (act)
      heapOpsPkg::actAdd, heapOpsPkg::actAddAfter:      return current + operand;
      heapOpsPkg::actSubtract, heapOpsPkg::actSubAfter: return current - operand;
      heapOpsPkg::actOr:                                return current | operand;
      heapOpsPkg::actXor:                               return current ^ operand;
      default:                                          return current & operand;
    endcase
  endfunction

  task automatic runAction(heapOpsPkg::heapAction act, heapConfigPkg::arrayId arr,
                           heapConfigPkg::elementIndex idx, heapConfigPkg::heapElement value,
                           heapOpsPkg::heapErrorCode expErr, bit hasOut,
                           heapConfigPkg::heapElement expOut);
    action = act;
    array  = arr;
    index  = idx;
    in     = value;
    waitForEdge();                                      // DUT samples here
    action = heapOpsPkg::actIdle;
    if (expErr == heapOpsPkg::errNone && hasOut) begin
      expectedOut = expOut;                             // Otherwise out must hold
    end
    checkError("error", error, expErr);
    checkElement("out", out, expectedOut);
  endtask

  task automatic expectOut(heapOpsPkg::heapAction act, heapConfigPkg::arrayId arr,
                           heapConfigPkg::elementIndex idx, heapConfigPkg::heapElement value,
                           heapConfigPkg::heapElement expOut);
    runAction(act, arr, idx, value, heapOpsPkg::errNone, 1'b1, expOut);
  endtask

  task automatic expectQuiet(heapOpsPkg::heapAction act, heapConfigPkg::arrayId arr,
                             heapConfigPkg::elementIndex idx, heapConfigPkg::heapElement value);
    runAction(act, arr, idx, value, heapOpsPkg::errNone, 1'b0, '0);
  endtask

  task automatic expectError(heapOpsPkg::heapAction act, heapConfigPkg::arrayId arr,
                             heapConfigPkg::elementIndex idx, heapConfigPkg::heapElement value,
                             heapOpsPkg::heapErrorCode expErr);
    runAction(act, arr, idx, value, expErr, 1'b0, '0);
  endtask

  task automatic applyReset;
    reset = 1'b1;
    waitForEdge();
    waitForEdge();                                      // Held for 2 cycles
    reset       = 1'b0;
    expectedOut = '0;
    checkError("error", error, heapOpsPkg::errNone);
    checkElement("out", out, '0);
  endtask

  // Reset action, then one fresh array that is granted id 0
  task automatic startWithOneArray;
    expectQuiet(heapOpsPkg::actReset, 0, 0, 0);
    expectOut(heapOpsPkg::actAlloc, 0, 0, 0, 0);
  endtask

  //--------------------------------------------------------------------
  // Directed tests
  //--------------------------------------------------------------------
  task automatic testAllocation;
    for (int i = 0; i < heapConfigPkg::ARRAY_COUNT; i++) begin
      expectOut(heapOpsPkg::actAlloc, 0, 0, 0, heapConfigPkg::heapElement'(i));
    end
    expectError(heapOpsPkg::actAlloc, 0, 0, 0, heapOpsPkg::errOutOfMemory);
    expectQuiet(heapOpsPkg::actFree, 1, 0, 0);
    expectOut(heapOpsPkg::actAlloc, 0, 0, 0, 1);        // Freed id comes back
    expectQuiet(heapOpsPkg::actFree, 2, 0, 0);
    expectError(heapOpsPkg::actFree, 2, 0, 0, heapOpsPkg::errFreed);   // Double free
    expectQuiet(heapOpsPkg::actReset, 0, 0, 0);
    expectError(heapOpsPkg::actRead, 0, 0, 0, heapOpsPkg::errNotAllocated);
    expectOut(heapOpsPkg::actAlloc, 0, 0, 0, 0);        // Ids restart at 0
  endtask

  task automatic testWriteRead;
    heapConfigPkg::heapElement first;
    heapConfigPkg::heapElement third;
    first = nextOperand();
    third = nextOperand();
    startWithOneArray();
    expectOut(heapOpsPkg::actWrite, 0, 0, first, first);   // Echoed on out
    expectOut(heapOpsPkg::actSize, 0, 0, 0, 1);
    expectOut(heapOpsPkg::actWrite, 0, 2, third, third);
    expectOut(heapOpsPkg::actSize, 0, 0, 0, 3);         // Extended to index plus one
    expectOut(heapOpsPkg::actRead, 0, 0, 0, first);
    expectOut(heapOpsPkg::actRead, 0, 2, 0, third);
    expectError(heapOpsPkg::actRead, 0, 3, 0, heapOpsPkg::errOutOfBounds);
  endtask

  task automatic testPushPop;
    heapConfigPkg::heapElement pushed [heapConfigPkg::ARRAY_LENGTH];
    startWithOneArray();
    for (int i = 0; i < heapConfigPkg::ARRAY_LENGTH; i++) begin
      pushed[i] = nextOperand();
      expectQuiet(heapOpsPkg::actPush, 0, 0, pushed[i]);
    end
    expectError(heapOpsPkg::actPush, 0, 0, 12'h5a5, heapOpsPkg::errFull);
    for (int i = heapConfigPkg::ARRAY_LENGTH - 1; i >= 0; i--) begin
      expectOut(heapOpsPkg::actPop, 0, 0, 0, pushed[i]);   // Last in, first out
    end
    expectError(heapOpsPkg::actPop, 0, 0, 0, heapOpsPkg::errEmpty);
    expectError(heapOpsPkg::actResize, 0, 0, 5, heapOpsPkg::errTooLarge);
    expectQuiet(heapOpsPkg::actResize, 0, 0, 2);
    expectOut(heapOpsPkg::actSize, 0, 0, 0, 2);
  endtask

  // Two arrays, writes, a resize and an insert in the middle
  task automatic testFpgaScenario;
    startWithOneArray();
    expectOut(heapOpsPkg::actAlloc, 0, 0, 0, 1);
    for (int i = 0; i < 3; i++) begin
      expectOut(heapOpsPkg::actWrite, 1, heapConfigPkg::elementIndex'(i),
                heapConfigPkg::heapElement'(i), heapConfigPkg::heapElement'(i));
    end
    expectQuiet(heapOpsPkg::actResize, 1, 0, 3);
    expectQuiet(heapOpsPkg::actUp, 1, 2, 99);           // 0 1 99 2
    expectOut(heapOpsPkg::actSize, 1, 0, 0, 4);
    expectOut(heapOpsPkg::actRead, 1, 0, 0, 0);
    expectOut(heapOpsPkg::actRead, 1, 1, 0, 1);
    expectOut(heapOpsPkg::actRead, 1, 2, 0, 99);
    expectOut(heapOpsPkg::actRead, 1, 3, 0, 2);
  endtask

  task automatic checkArithmetic(heapOpsPkg::heapAction act);
    heapConfigPkg::heapElement current;
    heapConfigPkg::heapElement operand;
    heapConfigPkg::heapElement updated;
    heapConfigPkg::heapElement reported;
    current  = nextOperand();
    operand  = nextOperand();
    updated  = applyOperation(act, current, operand);
    reported = (act == heapOpsPkg::actAddAfter || act == heapOpsPkg::actSubAfter) ?
               current : updated;                       // After variants give old value
    expectOut(heapOpsPkg::actWrite, 0, 1, current, current);
    expectOut(act, 0, 1, operand, reported);
    expectOut(heapOpsPkg::actRead, 0, 1, 0, updated);   // Stored result
  endtask

  task automatic testArithmetic;
    startWithOneArray();
    checkArithmetic(heapOpsPkg::actAdd);
    checkArithmetic(heapOpsPkg::actAddAfter);
    checkArithmetic(heapOpsPkg::actSubtract);
    checkArithmetic(heapOpsPkg::actSubAfter);
    checkArithmetic(heapOpsPkg::actOr);
    checkArithmetic(heapOpsPkg::actXor);
    checkArithmetic(heapOpsPkg::actAnd);
  endtask

  //--------------------------------------------------------------------
  // Test sequence
  //--------------------------------------------------------------------
  initial begin
    reset       = 1'b1;
    action      = heapOpsPkg::actIdle;
    array       = '0;
    index       = '0;
    in          = '0;
    expectedOut = '0;
    #1;                                                 // Odd ns offset from edges
    applyReset();
    testAllocation();
    testWriteRead();
    testPushPop();
    testFpgaScenario();
    testArithmetic();
    $display("Test completed successfully");
    $finish;
  end

endmodule

/* compile.f */
hw/heapConfigPkg.sv
hw/heapOpsPkg.sv
hw/heapStoreIf.sv
hw/heapAllocIf.sv
hw/heapAllocator.sv
hw/arrayStore.sv
hw/heapCommandUnit.sv
hw/heapMemory.sv
tests/heapMemoryTb.sv
